/* hdl/dcache_pkg.sv */
`default_nettype none

package dcache_pkg;

   // Bus widths
   localparam int ADDR_W = 32;
   localparam int DATA_W = 32;
   localparam int BYTE_W = DATA_W / 8;

   // Line and set geometry
   localparam int OFFSET_W   = 5;
   localparam int WORD_W     = 3;
   localparam int LINE_WORDS = 1 << WORD_W;
   localparam int SET_W      = 5;
   localparam int SETS       = 1 << SET_W;
   localparam int TAG_W      = ADDR_W - OFFSET_W - SET_W;

   // Byte offset inside a word
   localparam int BOFS_W = OFFSET_W - WORD_W;

   // Field view of an address word
   typedef struct packed {
      logic [TAG_W-1:0]  tag;
      logic [SET_W-1:0]  set;
      logic [WORD_W-1:0] word;
      logic [BOFS_W-1:0] byte_ofs;
   } dcache_addr_s;

   // Same word seen raw or split into fields
   typedef union packed {
      logic [ADDR_W-1:0] raw;
      dcache_addr_s      f;
   } dcache_addr_u;

   // Controller FSM states
   typedef enum logic [2:0] {
      IDLE,
      LOOKUP,
      WRITE,
      REFILL,
      RELOOK,
      INVAL,
      DONE
   } ctrl_state_e;

endpackage

`default_nettype wire

/* hdl/dcache_way_if.sv */
`timescale 1ns/1ps
`default_nettype none

interface dcache_way_if
   import dcache_pkg::*;
#(
   parameter int WAYS = 2
);

   // Read address, broadcast to every way
   logic [SET_W-1:0]  rd_set;
   logic [WORD_W-1:0] rd_word;

   // Tag the ways compare against
   logic [TAG_W-1:0]  cmp_tag;

   // Shared write port
   logic [SET_W-1:0]  wr_set;
   logic [WORD_W-1:0] wr_word;
   logic [DATA_W-1:0] wr_data;
   logic [TAG_W-1:0]  wr_tag;
   logic              wr_valid;

   // One enable bit per way
   logic [WAYS-1:0]   data_we;
   logic [WAYS-1:0]   tag_we;

   // Each way drives its own bit and slot
   wire  [WAYS-1:0]             way_hit;
   wire  [WAYS-1:0][DATA_W-1:0] way_rdata;

   modport ctrl (
      output rd_set, rd_word, cmp_tag,
      output wr_set, wr_word, wr_data, wr_tag, wr_valid,
      output data_we, tag_we
   );

   modport way (
      input  rd_set, rd_word, cmp_tag,
      input  wr_set, wr_word, wr_data, wr_tag, wr_valid,
      input  data_we, tag_we,
      output way_hit, way_rdata
   );

   modport sel (
      input  way_hit, way_rdata
   );

endinterface

`default_nettype wire

/* hdl/dcache_way.sv */
`timescale 1ns/1ps
`default_nettype none

module dcache_way
   import dcache_pkg::*;
#(
   parameter int WAY_ID = 0
) (
   input  logic      clk,
   dcache_way_if.way bus
);

   // Tag and valid per set
   logic [TAG_W-1:0]  tag_mem   [SETS];
   logic              valid_mem [SETS];
   // Eight words per set
   logic [DATA_W-1:0] data_mem  [SETS*LINE_WORDS];

   // Synchronous read outputs
   logic [TAG_W-1:0]  tag_q;
   logic              valid_q;
   logic [DATA_W-1:0] data_q;

   // Write side
   always_ff @(posedge clk) begin
      if (bus.tag_we[WAY_ID]) begin
         tag_mem[bus.wr_set]   <= bus.wr_tag;
         valid_mem[bus.wr_set] <= bus.wr_valid;
      end
      if (bus.data_we[WAY_ID]) begin
         data_mem[{bus.wr_set, bus.wr_word}] <= bus.wr_data;
      end
   end

   // Read side, old data on a same-cycle write
   always_ff @(posedge clk) begin
      tag_q   <= tag_mem[bus.rd_set];
      valid_q <= valid_mem[bus.rd_set];
      data_q  <= data_mem[{bus.rd_set, bus.rd_word}];
   end

   // Tag compare
   assign bus.way_hit[WAY_ID]   = valid_q & (tag_q == bus.cmp_tag);
   assign bus.way_rdata[WAY_ID] = data_q;

endmodule

`default_nettype wire

/* hdl/dcache_select.sv */
`timescale 1ns/1ps
`default_nettype none

module dcache_select
   import dcache_pkg::*;
#(
   parameter int WAYS = 2
) (
   dcache_way_if.sel         bus,
   output logic              hit_o,
   output logic [WAYS-1:0]   hit_way_o,
   output logic [DATA_W-1:0] rdata_o
);

   // Any way hitting is a cache hit
   assign hit_o = |bus.way_hit;

   // One-hot vector passed on for the write enable
   assign hit_way_o = bus.way_hit;

   // AND-OR mux, at most one way hits
   always_comb begin
      rdata_o = '0;
      for (int w = 0; w < WAYS; w++) begin
         rdata_o = rdata_o | ({DATA_W{bus.way_hit[w]}} & bus.way_rdata[w]);
      end
   end

endmodule

`default_nettype wire

/* hdl/dcache_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

module dcache_ctrl
   import dcache_pkg::*;
#(
   parameter int WAYS = 2
) (
   input  logic              clk,
   input  logic              rst,
   // CPU side
   input  logic              cpu_req_i,
   input  logic              cpu_we_i,
   input  logic [ADDR_W-1:0] cpu_adr_i,
   input  logic [DATA_W-1:0] cpu_dat_i,
   input  logic [BYTE_W-1:0] cpu_bsel_i,
   output logic              cpu_ack_o,
   output logic              cpu_hit_o,
   output logic [DATA_W-1:0] cpu_dat_o,
   // Memory side
   output logic              mem_req_o,
   output logic [ADDR_W-1:0] mem_adr_o,
   input  logic              mem_ack_i,
   input  logic [DATA_W-1:0] mem_dat_i,
   // Invalidate side
   input  logic              inv_req_i,
   input  logic [ADDR_W-1:0] inv_adr_i,
   output logic              inv_ack_o,
   // From the selector
   input  logic              hit_i,
   input  logic [DATA_W-1:0] rdata_i,
   input  logic [WAYS-1:0]   hit_way_i,
   dcache_way_if.ctrl        bus
);

   // Victim pointer width, kept at one bit for a single way
   localparam int VIC_W = (WAYS > 1) ? $clog2(WAYS) : 1;

   ctrl_state_e       state;
   dcache_addr_u      cpu_adr_u;
   dcache_addr_u      inv_adr_u;
   dcache_addr_u      addr_q;
   dcache_addr_u      mem_adr_u;
   logic [SET_W-1:0]  inv_set_q;
   logic              inv_q;
   logic              hit_q;
   logic [DATA_W-1:0] dat_q;
   logic              mem_req_q;
   // Refill word count, top bit marks a full line
   logic [WORD_W:0]   cnt;
   // Set walk after reset
   logic [SET_W:0]    clr_cnt;
   logic              clr_busy;
   logic              fill_we;
   logic              fill_last;
   logic [DATA_W-1:0] merge_data;
   // Per-set FIFO victim pointers
   logic [VIC_W-1:0]  vic_ptr [SETS];
   logic [VIC_W-1:0]  vic_cur;
   logic [VIC_W-1:0]  vic_next;
   logic [WAYS-1:0]   vic_q;

   assign cpu_adr_u.raw = cpu_adr_i;
   assign inv_adr_u.raw = inv_adr_i;

   assign clr_busy  = ~clr_cnt[SET_W];
   // One word lands per memory handshake
   assign fill_we   = (state == REFILL) & mem_req_q & mem_ack_i;
   assign fill_last = fill_we & (cnt[WORD_W-1:0] == WORD_W'(LINE_WORDS - 1));

   assign vic_cur  = vic_ptr[addr_q.f.set];
   assign vic_next = (WAYS == 1) ? VIC_W'(0) : vic_cur + 1'b1;

   // Sequencing FSM
   always_ff @(posedge clk) begin
      if (rst) begin
         state     <= IDLE;
         inv_q     <= 1'b0;
         mem_req_q <= 1'b0;
         cnt       <= '0;
         clr_cnt   <= '0;
      end else begin
         if (clr_busy) begin
            clr_cnt <= clr_cnt + 1'b1;
         end
         case (state)
            IDLE: begin
               // Invalidate wins over a CPU request
               if (!clr_busy && inv_req_i) begin
                  inv_q <= 1'b1;
                  state <= INVAL;
               end else if (!clr_busy && cpu_req_i) begin
                  inv_q <= 1'b0;
                  state <= LOOKUP;
               end
            end
            LOOKUP: begin
               if (cpu_we_i) begin
                  state <= WRITE;
               end else if (hit_i) begin
                  state <= DONE;
               end else begin
                  cnt   <= '0;
                  state <= REFILL;
               end
            end
            WRITE: state <= DONE;
            REFILL: begin
               if (mem_req_q) begin
                  // Word taken, release the request
                  if (mem_ack_i) begin
                     mem_req_q <= 1'b0;
                     cnt       <= cnt + 1'b1;
                  end
               end else if (!mem_ack_i) begin
                  if (cnt[WORD_W]) begin
                     state <= RELOOK;
                  end else begin
                     mem_req_q <= 1'b1;
                  end
               end
            end
            RELOOK: state <= DONE;
            INVAL: state <= DONE;
            DONE: begin
               // Hold the ack until the request drops
               if (inv_q ? !inv_req_i : !cpu_req_i) begin
                  state <= IDLE;
               end
            end
            default: state <= IDLE;
         endcase
      end
   end

   // Request payload
   always_ff @(posedge clk) begin
      if (state == IDLE) begin
         addr_q    <= cpu_adr_u;
         inv_set_q <= inv_adr_u.f.set;
      end
      if (state == LOOKUP) begin
         hit_q <= hit_i;
         dat_q <= rdata_i;
         vic_q <= WAYS'(1) << vic_cur;
      end
      // Second lookup after the line is in
      if (state == RELOOK) begin
         dat_q <= rdata_i;
      end
   end

   // Pointer moves on when a line is complete
   always_ff @(posedge clk) begin
      if (clr_busy) begin
         vic_ptr[clr_cnt[SET_W-1:0]] <= '0;
      end else if (fill_last) begin
         vic_ptr[addr_q.f.set] <= vic_next;
      end
   end

   // Byte lane merge of store data over the hit word
   always_comb begin
      for (int b = 0; b < BYTE_W; b++) begin
         merge_data[8*b +: 8] = cpu_bsel_i[b] ? cpu_dat_i[8*b +: 8] : rdata_i[8*b +: 8];
      end
   end

   // Read side follows the CPU address only while idle
   assign bus.rd_set  = (state == IDLE) ? cpu_adr_u.f.set : addr_q.f.set;
   assign bus.rd_word = (state == IDLE) ? cpu_adr_u.f.word : addr_q.f.word;
   assign bus.cmp_tag = addr_q.f.tag;
   assign bus.wr_tag  = addr_q.f.tag;

   // Write port mux
   always_comb begin
      bus.wr_set   = addr_q.f.set;
      bus.wr_word  = addr_q.f.word;
      bus.wr_data  = merge_data;
      bus.wr_valid = 1'b0;
      bus.data_we  = '0;
      bus.tag_we   = '0;
      if (clr_busy) begin
         bus.wr_set = clr_cnt[SET_W-1:0];
         bus.tag_we = '1;
      end else if (state == INVAL) begin
         bus.wr_set = inv_set_q;
         bus.tag_we = '1;
      end else if (state == WRITE) begin
         // Write miss leaves the cache alone
         if (hit_i) begin
            bus.data_we = hit_way_i;
         end
      end else if (fill_we) begin
         bus.wr_word  = cnt[WORD_W-1:0];
         bus.wr_data  = mem_dat_i;
         bus.data_we  = vic_q;
         // Valid drops on the first word, returns with the tag on the last
         if (cnt[WORD_W-1:0] == '0 || fill_last) begin
            bus.tag_we = vic_q;
         end
         bus.wr_valid = fill_last;
      end
   end

   // Word address of the current refill beat
   always_comb begin
      mem_adr_u            = addr_q;
      mem_adr_u.f.word     = cnt[WORD_W-1:0];
      mem_adr_u.f.byte_ofs = '0;
   end

   assign mem_adr_o = mem_adr_u.raw;
   assign mem_req_o = mem_req_q;
   assign cpu_ack_o = ~inv_q & ((state == WRITE) | (state == DONE));
   assign inv_ack_o = inv_q & (state == DONE);
   assign cpu_hit_o = hit_q;
   assign cpu_dat_o = dat_q;

endmodule

`default_nettype wire

/* hdl/dcache_top.sv */
`timescale 1ns/1ps
`default_nettype none

module dcache_top
   import dcache_pkg::*;
#(
   parameter int WAYS = 2
) (
   input  logic              clk,
   input  logic              rst,
   // CPU port
   input  logic              cpu_req_i,
   input  logic              cpu_we_i,
   input  logic [DATA_W-1:0] cpu_adr_i,
   input  logic [DATA_W-1:0] cpu_dat_i,
   input  logic [BYTE_W-1:0] cpu_bsel_i,
   output logic              cpu_ack_o,
   output logic              cpu_hit_o,
   output logic [DATA_W-1:0] cpu_dat_o,
   // Memory port
   output logic              mem_req_o,
   output logic [ADDR_W-1:0] mem_adr_o,
   input  logic              mem_ack_i,
   input  logic [DATA_W-1:0] mem_dat_i,
   // Invalidate port
   input  logic              inv_req_i,
   input  logic [ADDR_W-1:0] inv_adr_i,
   output logic              inv_ack_o
);

   // Selector back to controller
   logic              hit;
   logic [WAYS-1:0]   hit_way;
   logic [DATA_W-1:0] rdata;

   // Way count must be 1, 2 or 4
   if (WAYS != 1 && WAYS != 2 && WAYS != 4) begin : g_ways_check
      $error("dcache_top WAYS must be 1, 2 or 4");
   end

   dcache_way_if #(.WAYS(WAYS)) way_bus ();

   dcache_ctrl #(.WAYS(WAYS)) u_ctrl (
      .clk        (clk),
      .rst        (rst),
      .cpu_req_i  (cpu_req_i),
      .cpu_we_i   (cpu_we_i),
      .cpu_adr_i  (cpu_adr_i),
      .cpu_dat_i  (cpu_dat_i),
      .cpu_bsel_i (cpu_bsel_i),
      .cpu_ack_o  (cpu_ack_o),
      .cpu_hit_o  (cpu_hit_o),
      .cpu_dat_o  (cpu_dat_o),
      .mem_req_o  (mem_req_o),
      .mem_adr_o  (mem_adr_o),
      .mem_ack_i  (mem_ack_i),
      .mem_dat_i  (mem_dat_i),
      .inv_req_i  (inv_req_i),
      .inv_adr_i  (inv_adr_i),
      .inv_ack_o  (inv_ack_o),
      .hit_i      (hit),
      .rdata_i    (rdata),
      .hit_way_i  (hit_way),
      .bus        (way_bus.ctrl)
   );

   // One storage block per way
   for (genvar w = 0; w < WAYS; w++) begin : g_way
      dcache_way #(.WAY_ID(w)) u_way (
         .clk (clk),
         .bus (way_bus.way)
      );
   end

   dcache_select #(.WAYS(WAYS)) u_sel (
      .bus       (way_bus.sel),
      .hit_o     (hit),
      .hit_way_o (hit_way),
      .rdata_o   (rdata)
   );

endmodule

`default_nettype wire

/* sim/dcache_asserts.sv */
`timescale 1ns/1ps
`default_nettype none

module dcache_asserts
   import dcache_pkg::*;
(
   input logic        clk,
   input logic        rst,
   input logic        cpu_req_i,
   input logic        cpu_we_i,
   input logic        cpu_ack_o,
   input logic        mem_req_o,
   input logic        mem_ack_i,
   input logic        hit_i,
   input ctrl_state_e state
);

   // Failures seen so far, read back by the testbench
   int fail_count = 0;

   task automatic record_failure(input string msg);
      $error("%s", msg);
      fail_count++;
   endtask

   // CPU ack only rises against a live request, seen at the edge that raised it
   a_ack_req : assert property (@(posedge clk) disable iff (rst)
      $rose(cpu_ack_o) |-> $past(cpu_req_i))
      else record_failure("cpu_ack_o rose without cpu_req_i");

   // Ack only falls once the request has dropped
   a_ack_drop : assert property (@(posedge clk) disable iff (rst)
      $fell(cpu_ack_o) |-> !$past(cpu_req_i))
      else record_failure("cpu_ack_o fell while cpu_req_i was high");

   // Memory request stays up until memory acks
   a_mem_hold : assert property (@(posedge clk) disable iff (rst)
      mem_req_o && !mem_ack_i |=> mem_req_o)
      else record_failure("mem_req_o dropped before mem_ack_i");

   a_mem_state : assert property (@(posedge clk) disable iff (rst)
      mem_req_o |-> state == REFILL)
      else record_failure("mem_req_o outside REFILL");

   // Read hit, ack two edges after the request is sampled
   a_hit_lat : assert property (@(posedge clk) disable iff (rst)
      (state == IDLE) ##1 (state == LOOKUP && !cpu_we_i && hit_i) |=> $rose(cpu_ack_o))
      else record_failure("read hit ack not two cycles after request");

endmodule

bind dcache_ctrl dcache_asserts u_asserts (.*);

`default_nettype wire

/* sim/tb_dcache.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_dcache
   import dcache_pkg::*;
();

   localparam int WAYS    = 2;
   localparam int TIMEOUT = 200;

   logic              clk;
   logic              rst;
   logic              cpu_req_i;
   logic              cpu_we_i;
   logic [ADDR_W-1:0] cpu_adr_i;
   logic [DATA_W-1:0] cpu_dat_i;
   logic [BYTE_W-1:0] cpu_bsel_i;
   logic              cpu_ack_o;
   logic              cpu_hit_o;
   logic [DATA_W-1:0] cpu_dat_o;
   logic              mem_req_o;
   logic [ADDR_W-1:0] mem_adr_o;
   logic              mem_ack_i;
   logic [DATA_W-1:0] mem_dat_i;
   logic              inv_req_i;
   logic [ADDR_W-1:0] inv_adr_i;
   logic              inv_ack_o;

   integer            seed;
   int                errors;
   int                timeouts;
   // Memory beats seen for the current access
   int                beats;
   logic [1:0]        mem_delay;
   logic [ADDR_W-1:0] fill_base;
   logic              exp_hit;
   logic              exp_we;
   logic [DATA_W-1:0] exp_dat;

   // Model of resident tags and lines, FIFO victim per set
   logic [TAG_W-1:0]  m_tag  [SETS][WAYS];
   logic              m_val  [SETS][WAYS];
   logic [DATA_W-1:0] m_line [SETS][WAYS][LINE_WORDS];
   int                m_ptr  [SETS];

   dcache_top #(.WAYS(WAYS)) UUT (.*);

   initial begin
      clk = 1'b0;
      forever #2 clk = ~clk;
   end

   // Backing memory content rule
   function automatic logic [DATA_W-1:0] mem_word(input logic [ADDR_W-1:0] adr);
      return adr ^ 32'h5A3C_96E1;
   endfunction

   function automatic logic [ADDR_W-1:0] make_adr(input int tag, input int set, input int word);
      dcache_addr_u a;
      a.f.tag      = TAG_W'(tag);
      a.f.set      = SET_W'(set);
      a.f.word     = WORD_W'(word);
      a.f.byte_ofs = '0;
      return a.raw;
   endfunction

   task automatic model_access(input logic we, input logic [ADDR_W-1:0] adr,
                               input logic [DATA_W-1:0] dat, input logic [BYTE_W-1:0] bsel);
      dcache_addr_u a;
      int           hw;
      a.raw = adr;
      hw    = -1;
      for (int w = 0; w < WAYS; w++) begin
         if (m_val[a.f.set][w] && m_tag[a.f.set][w] == a.f.tag) begin
            hw = w;
         end
      end
      exp_hit = (hw >= 0);
      exp_we  = we;
      if (exp_hit && we) begin
         for (int b = 0; b < BYTE_W; b++) begin
            if (bsel[b]) begin
               m_line[a.f.set][hw][a.f.word][8*b +: 8] = dat[8*b +: 8];
            end
         end
      end else if (!exp_hit && !we) begin
         // Oldest way takes the new line
         hw = m_ptr[a.f.set];
         for (int k = 0; k < LINE_WORDS; k++) begin
            m_line[a.f.set][hw][k] = mem_word({a.f.tag, a.f.set, WORD_W'(k), BOFS_W'(0)});
         end
         m_tag[a.f.set][hw] = a.f.tag;
         m_val[a.f.set][hw] = 1'b1;
         m_ptr[a.f.set]     = (hw + 1) % WAYS;
      end
      exp_dat   = (hw >= 0) ? m_line[a.f.set][hw][a.f.word] : '0;
      fill_base = {a.f.tag, a.f.set, OFFSET_W'(0)};
   endtask

   task automatic model_inval(input logic [ADDR_W-1:0] adr);
      dcache_addr_u a;
      a.raw = adr;
      for (int w = 0; w < WAYS; w++) begin
         m_val[a.f.set][w] = 1'b0;
      end
   endtask

   task automatic cpu_start(input logic we, input logic [ADDR_W-1:0] adr,
                            input logic [DATA_W-1:0] dat, input logic [BYTE_W-1:0] bsel);
      model_access(we, adr, dat, bsel);
      beats      = 0;
      cpu_we_i   = we;
      cpu_adr_i  = adr;
      cpu_dat_i  = dat;
      cpu_bsel_i = bsel;
      cpu_req_i  = 1'b1;
   endtask

   task automatic cpu_finish(input logic chk_lat);
      int cycles;
      cycles = 0;
      while (!cpu_ack_o && cycles < TIMEOUT) begin
         @(negedge clk);
         cycles++;
      end
      if (!cpu_ack_o) begin
         $display("Timeout at %0t: no cpu_ack_o for address %h", $time, cpu_adr_i);
         timeouts++;
      end else begin
         assert (cpu_hit_o == exp_hit) else begin
            $display("Mismatch at %0t: hit %0b, expected %0b", $time, cpu_hit_o, exp_hit);
            errors++;
         end
         assert (exp_we || cpu_dat_o == exp_dat) else begin
            $display("Mismatch at %0t: read %h, expected %h", $time, cpu_dat_o, exp_dat);
            errors++;
         end
         // Hits and all writes take two cycles
         assert (!chk_lat || !(exp_hit || exp_we) || cycles == 2) else begin
            $display("Mismatch at %0t: ack after %0d cycles, expected 2", $time, cycles);
            errors++;
         end
         assert (beats == ((!exp_hit && !exp_we) ? LINE_WORDS : 0)) else begin
            $display("Mismatch at %0t: %0d memory beats", $time, beats);
            errors++;
         end
      end
      cpu_req_i = 1'b0;
      cycles    = 0;
      while (cpu_ack_o && cycles < TIMEOUT) begin
         @(negedge clk);
         cycles++;
      end
      if (cpu_ack_o) begin
         $display("Timeout at %0t: cpu_ack_o stuck high", $time);
         timeouts++;
      end
   endtask

   task automatic cpu_access(input logic we, input logic [ADDR_W-1:0] adr,
                             input logic [DATA_W-1:0] dat, input logic [BYTE_W-1:0] bsel);
      cpu_start(we, adr, dat, bsel);
      cpu_finish(1'b1);
   endtask

   task automatic cpu_read(input logic [ADDR_W-1:0] adr);
      cpu_access(1'b0, adr, '0, '0);
   endtask

   task automatic inv_drive(input logic [ADDR_W-1:0] adr);
      int cycles;
      inv_adr_i = adr;
      inv_req_i = 1'b1;
      cycles    = 0;
      while (!inv_ack_o && cycles < TIMEOUT) begin
         @(negedge clk);
         cycles++;
         // CPU side stays quiet until the invalidate is through
         assert (!cpu_ack_o) else begin
            $display("Mismatch at %0t: cpu_ack_o high during invalidate", $time);
            errors++;
         end
      end
      if (!inv_ack_o) begin
         $display("Timeout at %0t: no inv_ack_o", $time);
         timeouts++;
      end else begin
         assert (cycles == 2) else begin
            $display("Mismatch at %0t: inv ack after %0d cycles, expected 2", $time, cycles);
            errors++;
         end
      end
      inv_req_i = 1'b0;
      cycles    = 0;
      while (inv_ack_o && cycles < TIMEOUT) begin
         @(negedge clk);
         cycles++;
      end
      if (inv_ack_o) begin
         $display("Timeout at %0t: inv_ack_o stuck high", $time);
         timeouts++;
      end
   endtask

   // Memory side, four-phase with 0 to 3 cycles of delay
   initial begin
      mem_ack_i = 1'b0;
      mem_dat_i = '0;
      mem_delay = 2'd0;
      forever begin
         @(negedge clk);
         if (mem_ack_i) begin
            if (!mem_req_o) begin
               mem_ack_i = 1'b0;
               mem_delay = 2'($random(seed));
            end
         end else if (mem_req_o) begin
            if (mem_delay != 2'd0) begin
               mem_delay--;
            end else begin
               // Words of a line come in order
               assert (mem_adr_o == fill_base + ADDR_W'(4 * beats)) else begin
                  $display("Mismatch at %0t: memory address %h, expected %h",
                           $time, mem_adr_o, fill_base + ADDR_W'(4 * beats));
                  errors++;
               end
               mem_dat_i = mem_word(mem_adr_o);
               mem_ack_i = 1'b1;
               beats++;
            end
         end
      end
   end

   initial begin
      logic [31:0]       r;
      logic [ADDR_W-1:0] adr;
      int                asrt;
      seed       = 18;
      errors     = 0;
      timeouts   = 0;
      beats      = 0;
      fill_base  = '0;
      rst        = 1'b1;
      cpu_req_i  = 1'b0;
      cpu_we_i   = 1'b0;
      cpu_adr_i  = '0;
      cpu_dat_i  = '0;
      cpu_bsel_i = '0;
      inv_req_i  = 1'b0;
      inv_adr_i  = '0;
      for (int s = 0; s < SETS; s++) begin
         m_ptr[s] = 0;
         for (int w = 0; w < WAYS; w++) begin
            m_val[s][w] = 1'b0;
         end
      end
      repeat (8) @(posedge clk);
      @(negedge clk);
      rst = 1'b0;
      // Valid clear walks all 32 sets
      repeat (SETS + 2) @(negedge clk);

      // Cold miss, then every word of the line hits
      cpu_read(make_adr(1, 3, 5));
      for (int k = 0; k < LINE_WORDS; k++) begin
         cpu_read(make_adr(1, 3, k));
      end
      // Partial store on a hit, then read back
      cpu_access(1'b1, make_adr(1, 3, 2), 32'hC0DE_F00D, BYTE_W'($random(seed)));
      cpu_read(make_adr(1, 3, 2));
      // Store miss leaves memory value for the refill
      cpu_access(1'b1, make_adr(2, 9, 1), 32'h1234_5678, '1);
      cpu_read(make_adr(2, 9, 1));
      // Third tag in set 3 pushes out the oldest
      cpu_read(make_adr(2, 3, 0));
      cpu_read(make_adr(3, 3, 4));
      cpu_read(make_adr(2, 3, 7));
      cpu_read(make_adr(1, 3, 2));
      cpu_read(make_adr(3, 3, 1));
      // Invalidate set 3 only
      model_inval(make_adr(0, 3, 0));
      inv_drive(make_adr(0, 3, 0));
      cpu_read(make_adr(1, 3, 2));
      cpu_read(make_adr(3, 3, 6));
      cpu_read(make_adr(2, 9, 3));
      // Invalidate and read raised in the same cycle
      model_inval(make_adr(0, 9, 0));
      cpu_start(1'b0, make_adr(2, 9, 3), '0, '0);
      inv_drive(make_adr(0, 9, 0));
      cpu_finish(1'b0);

      // Random mix over a small conflicting pool
      for (int i = 0; i < 80; i++) begin
         r   = $random(seed);
         adr = make_adr(1 + int'(r[1:0]) % 3, r[2] ? 3 : 9, int'(r[5:3]));
         if (r[9:6] == 4'd0) begin
            model_inval(adr);
            inv_drive(adr);
         end else begin
            cpu_access(r[10], adr, $random(seed), r[14:11]);
         end
      end

      asrt = UUT.u_ctrl.u_asserts.fail_count;
      $display("Checks done: %0d mismatches, %0d timeouts, %0d assertion failures",
               errors, timeouts, asrt);
      if (errors == 0 && timeouts == 0 && asrt == 0) begin
         $display("Simulation passed");
      end else begin
         $display("Simulation failed");
      end
      $finish;
   end

endmodule

`default_nettype wire

/* files.f */
hdl/dcache_pkg.sv
hdl/dcache_way_if.sv
hdl/dcache_way.sv
hdl/dcache_select.sv
hdl/dcache_ctrl.sv
hdl/dcache_top.sv
sim/dcache_asserts.sv
sim/tb_dcache.sv

/* Makefile */
TOP = tb_dcache

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert -f files.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -f files.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "^Simulation passed$$" sim.log

clean:
	rm -rf obj_dir sim.log
